/* sudoku_pkg.sv */
package sudoku_pkg;

    // board geometry
    localparam int BOARD_DIM  = 9;
    localparam int CELL_COUNT = 81;

    // 0 marks an empty cell
    typedef logic [3:0] digit_t;

    // row or column index, 0 to 8
    typedef logic [3:0] idx_t;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_peer,
        st_generate,
        st_play,
        st_done
    } stage_e;

    // row-major cell number
    function automatic logic [6:0] cell_index(
        input idx_t row,
        input idx_t col
    );
        logic [6:0] base;
        base = {3'b000, row} * 7'd9;
        cell_index = base + {3'b000, col};
    endfunction

    // 3x3 box number, boxes numbered row-major
    function automatic logic [3:0] box_of(
        input idx_t row,
        input idx_t col
    );
        logic [3:0] band;
        logic [3:0] stack;
        band   = row / 4'd3;
        stack  = col / 4'd3;
        box_of = band * 4'd3 + stack;
    endfunction

endpackage

/* cell_write_if.sv */
`timescale 1ns/10ps

interface cell_write_if;

    logic               valid;
    logic               ready;
    sudoku_pkg::idx_t   row;
    sudoku_pkg::idx_t   col;
    sudoku_pkg::digit_t digit;
    // set for a fixed puzzle cell
    logic               given;

    modport src (
        output valid,
        output row,
        output col,
        output digit,
        output given,
        input  ready
    );

    modport dst (
        input  valid,
        input  row,
        input  col,
        input  digit,
        input  given,
        output ready
    );

endinterface

/* lfsr.sv */
`timescale 1ns/10ps

module lfsr #(
    parameter logic [15:0] LFSR_SEED = 16'hace1
) (
    input  logic        clk,
    input  logic        rst,
    output logic [15:0] random
);

    logic [15:0] state;
    logic        feedback;

    // taps 16, 14, 13, 11
    assign feedback = state[15] ^ state[13] ^ state[12] ^ state[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LFSR_SEED;
        end else begin
            state <= {state[14:0], feedback};
        end
    end

    assign random = state;

endmodule

/* puzzle_generator.sv */
`timescale 1ns/10ps

module puzzle_generator (
    input  logic        clk,
    input  logic        rst,
    input  logic        gen_start,
    input  logic [15:0] random,
    output logic        gen_done,
    cell_write_if.src   gen_wr
);

    logic             active;
    logic             blank;
    logic [3:0]       offset;
    sudoku_pkg::idx_t row;
    sudoku_pkg::idx_t col;
    logic [3:0]       band;
    logic [5:0]       pattern_sum;
    logic [3:0]       solution;
    logic             fire;
    logic             last_cell;

    // row/3, taken from the box map with the row on the column side
    assign band = sudoku_pkg::box_of(4'd0, row);

    // shifted pattern, every row, column and box holds 1..9 once
    assign pattern_sum = 6'(row) * 6'd3 + 6'(band) + 6'(col) + 6'(offset);
    assign solution    = 4'(pattern_sum % 6'd9) + 4'd1;

    assign gen_wr.valid = active;
    assign gen_wr.row   = row;
    assign gen_wr.col   = col;
    assign gen_wr.digit = blank ? 4'd0 : solution;
    assign gen_wr.given = !blank;

    assign fire      = gen_wr.valid && gen_wr.ready;
    assign last_cell = sudoku_pkg::cell_index(row, col) == 7'(sudoku_pkg::CELL_COUNT - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            gen_done <= 1'b0;
            row      <= '0;
            col      <= '0;
        end else begin
            gen_done <= 1'b0;
            if (gen_start) begin
                active <= 1'b1;
                row    <= '0;
                col    <= '0;
                offset <= 4'(random % 16'd9);
                blank  <= &random[1:0];
            end else if (fire) begin
                // fresh blank decision for the next cell
                blank <= &random[1:0];
                if (last_cell) begin
                    active   <= 1'b0;
                    gen_done <= 1'b1;
                end else if (col == 4'd8) begin
                    col <= '0;
                    row <= row + 4'd1;
                end else begin
                    col <= col + 4'd1;
                end
            end
        end
    end

endmodule

/* board_keeper.sv */
`timescale 1ns/10ps

module board_keeper (
    input  logic               clk,
    input  logic               rst,
    input  logic               playing,
    cell_write_if.dst          gen_wr,
    cell_write_if.dst          play_wr,
    input  sudoku_pkg::idx_t   rd_row,
    input  sudoku_pkg::idx_t   rd_col,
    output sudoku_pkg::digit_t rd_digit,
    output logic               rd_given,
    output logic               solved
);

    sudoku_pkg::digit_t                board [sudoku_pkg::CELL_COUNT];
    logic [sudoku_pkg::CELL_COUNT-1:0] given_mask;

    logic               scanning;
    logic               scan_done;
    logic               scan_err;
    sudoku_pkg::idx_t   scan_row;
    sudoku_pkg::idx_t   scan_col;
    logic [8:0]         row_seen [sudoku_pkg::BOARD_DIM];
    logic [8:0]         col_seen [sudoku_pkg::BOARD_DIM];
    logic [8:0]         box_seen [sudoku_pkg::BOARD_DIM];

    sudoku_pkg::digit_t cur_digit;
    logic [3:0]         cur_box;
    logic [8:0]         cur_bit;
    logic               cur_bad;
    logic               gen_fire;
    logic               play_fire;
    logic [6:0]         gen_idx;
    logic [6:0]         play_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign gen_wr.ready  = !playing;
    assign play_wr.ready = playing && !scanning && !scan_done;

    assign gen_fire  = gen_wr.valid && gen_wr.ready;
    assign play_fire = play_wr.valid && play_wr.ready;
    assign gen_idx   = sudoku_pkg::cell_index(gen_wr.row, gen_wr.col);
    assign play_idx  = sudoku_pkg::cell_index(play_wr.row, play_wr.col);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // solution scan, one cell per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cur_digit = board[sudoku_pkg::cell_index(scan_row, scan_col)];
    assign cur_box   = sudoku_pkg::box_of(scan_row, scan_col);
    // empty or out-of-range digits shift out to zero
    assign cur_bit   = 9'b1 << (cur_digit - 4'd1);
    assign cur_bad   = (cur_digit == 4'd0) || (cur_digit > 4'd9)
                     || |(row_seen[scan_row] & cur_bit)
                     || |(col_seen[scan_col] & cur_bit)
                     || |(box_seen[cur_box] & cur_bit);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < sudoku_pkg::CELL_COUNT; i++) begin
                board[i] <= '0;
            end
            given_mask <= '0;
            scanning   <= 1'b0;
            scan_done  <= 1'b0;
            scan_err   <= 1'b0;
            scan_row   <= '0;
            scan_col   <= '0;
            solved     <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (gen_fire) begin
                board[gen_idx]      <= gen_wr.digit;
                given_mask[gen_idx] <= gen_wr.given;
                solved              <= 1'b0;
            end
            if (play_fire) begin
                // fixed cells swallow the write
                if (!given_mask[play_idx]) begin
                    board[play_idx] <= play_wr.digit;
                end
                scanning <= 1'b1;
                scan_err <= 1'b0;
                scan_row <= '0;
                scan_col <= '0;
                for (int g = 0; g < sudoku_pkg::BOARD_DIM; g++) begin
                    row_seen[g] <= '0;
                    col_seen[g] <= '0;
                    box_seen[g] <= '0;
                end
            end
            if (scanning) begin
                if (cur_bad) begin
                    scan_err <= 1'b1;
                end
                row_seen[scan_row] <= row_seen[scan_row] | cur_bit;
                col_seen[scan_col] <= col_seen[scan_col] | cur_bit;
                box_seen[cur_box]  <= box_seen[cur_box] | cur_bit;
                if (scan_col == 4'd8) begin
                    scan_col <= '0;
                    if (scan_row == 4'd8) begin
                        scanning  <= 1'b0;
                        scan_done <= 1'b1;
                    end else begin
                        scan_row <= scan_row + 4'd1;
                    end
                end else begin
                    scan_col <= scan_col + 4'd1;
                end
            end
            if (scan_done) begin
                solved <= !scan_err;
            end
        end
    end

    // readback for the display side
    assign rd_digit = board[sudoku_pkg::cell_index(rd_row, rd_col)];
    assign rd_given = given_mask[sudoku_pkg::cell_index(rd_row, rd_col)];

endmodule

/* game_stage.sv */
`timescale 1ns/10ps

module game_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               connect_req,
    input  logic               start_req,
    input  logic               return_req,
    input  logic               peer_connect,
    input  logic               peer_start,
    input  logic               peer_finish,
    input  logic               solved,
    input  logic               gen_done,
    output logic               gen_start,
    output logic               playing,
    output logic               send_connect,
    output logic               send_start,
    output logic               send_finish,
    output logic               is_slave,
    output logic               won,
    output sudoku_pkg::stage_e stage
);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage        <= sudoku_pkg::st_idle;
            gen_start    <= 1'b0;
            send_connect <= 1'b0;
            send_start   <= 1'b0;
            send_finish  <= 1'b0;
            is_slave     <= 1'b0;
            won          <= 1'b0;
        end else begin
            gen_start <= 1'b0;
            case (stage)
                sudoku_pkg::st_idle: begin
                    if (connect_req) begin
                        send_connect <= 1'b1;
                        stage        <= sudoku_pkg::st_wait_peer;
                    end
                end
                sudoku_pkg::st_wait_peer: begin
                    // local start makes this board the master
                    if (peer_connect && start_req) begin
                        send_start <= 1'b1;
                        is_slave   <= 1'b0;
                        gen_start  <= 1'b1;
                        stage      <= sudoku_pkg::st_generate;
                    end else if (peer_connect && peer_start) begin
                        is_slave  <= 1'b1;
                        gen_start <= 1'b1;
                        stage     <= sudoku_pkg::st_generate;
                    end
                end
                sudoku_pkg::st_generate: begin
                    if (gen_done) begin
                        stage <= sudoku_pkg::st_play;
                    end
                end
                sudoku_pkg::st_play: begin
                    if (solved) begin
                        send_finish <= 1'b1;
                        won         <= 1'b1;
                        stage       <= sudoku_pkg::st_done;
                    end else if (peer_finish) begin
                        won   <= 1'b0;
                        stage <= sudoku_pkg::st_done;
                    end
                end
                sudoku_pkg::st_done: begin
                    if (return_req) begin
                        send_connect <= 1'b0;
                        send_start   <= 1'b0;
                        send_finish  <= 1'b0;
                        won          <= 1'b0;
                        stage        <= sudoku_pkg::st_idle;
                    end
                end
                default: stage <= sudoku_pkg::st_idle;
            endcase
        end
    end

    assign playing = (stage == sudoku_pkg::st_play);

endmodule

/* play_timer.sv */
`timescale 1ns/10ps

module play_timer #(
    parameter int TICK_CYCLES = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        gen_start,
    input  logic        playing,
    output logic [15:0] time_spent
);

    // one extra bit so TICK_CYCLES of 1 still gets a counter
    localparam int TICK_W = $clog2(TICK_CYCLES + 1);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;

    assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst || gen_start) begin
            tick_cnt   <= '0;
            time_spent <= '0;
        end else if (playing) begin
            if (tick) begin
                tick_cnt <= '0;
                // saturate at full scale
                if (time_spent != 16'hffff) begin
                    time_spent <= time_spent + 16'd1;
                end
            end else begin
                tick_cnt <= tick_cnt + TICK_W'(1);
            end
        end
    end

endmodule

/* sudoku_top.sv */
`timescale 1ns/10ps

module sudoku_top #(
    parameter int          TICK_CYCLES = 100_000_000,
    parameter logic [15:0] LFSR_SEED   = 16'hace1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               connect_req,
    input  logic               start_req,
    input  logic               return_req,
    input  logic               peer_connect,
    input  logic               peer_start,
    input  logic               peer_finish,
    input  logic               entry_valid,
    input  sudoku_pkg::idx_t   entry_row,
    input  sudoku_pkg::idx_t   entry_col,
    input  sudoku_pkg::digit_t entry_digit,
    input  sudoku_pkg::idx_t   rd_row,
    input  sudoku_pkg::idx_t   rd_col,
    output logic               entry_ready,
    output sudoku_pkg::digit_t rd_digit,
    output logic               rd_given,
    output logic               send_connect,
    output logic               send_start,
    output logic               send_finish,
    output logic               is_slave,
    output logic               won,
    output sudoku_pkg::stage_e stage,
    output logic [15:0]        time_spent
);

    logic [15:0] random;
    logic        gen_start;
    logic        gen_done;
    logic        solved;
    logic        playing;

    cell_write_if gen_wr_if ();
    cell_write_if play_wr_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // player entry onto the write interface
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign play_wr_if.valid = entry_valid;
    assign play_wr_if.row   = entry_row;
    assign play_wr_if.col   = entry_col;
    assign play_wr_if.digit = entry_digit;
    assign play_wr_if.given = 1'b0;
    assign entry_ready      = play_wr_if.ready;

    lfsr #(
        .LFSR_SEED (LFSR_SEED)
    ) lfsr_inst (
        .clk    (clk),
        .rst    (rst),
        .random (random)
    );

    puzzle_generator puzzle_generator_inst (
        .clk       (clk),
        .rst       (rst),
        .gen_start (gen_start),
        .random    (random),
        .gen_done  (gen_done),
        .gen_wr    (gen_wr_if.src)
    );

    board_keeper board_keeper_inst (
        .clk      (clk),
        .rst      (rst),
        .playing  (playing),
        .gen_wr   (gen_wr_if.dst),
        .play_wr  (play_wr_if.dst),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_digit (rd_digit),
        .rd_given (rd_given),
        .solved   (solved)
    );

    game_stage game_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .connect_req  (connect_req),
        .start_req    (start_req),
        .return_req   (return_req),
        .peer_connect (peer_connect),
        .peer_start   (peer_start),
        .peer_finish  (peer_finish),
        .solved       (solved),
        .gen_done     (gen_done),
        .gen_start    (gen_start),
        .playing      (playing),
        .send_connect (send_connect),
        .send_start   (send_start),
        .send_finish  (send_finish),
        .is_slave     (is_slave),
        .won          (won),
        .stage        (stage)
    );

    play_timer #(
        .TICK_CYCLES (TICK_CYCLES)
    ) play_timer_inst (
        .clk        (clk),
        .rst        (rst),
        .gen_start  (gen_start),
        .playing    (playing),
        .time_spent (time_spent)
    );

endmodule

/* tb_sudoku_checker.sv */
`timescale 1ns/10ps

module tb_sudoku_checker (
    input logic               clk,
    input logic               rst,
    input logic               entry_ready,
    input logic               won,
    input logic               send_finish,
    input sudoku_pkg::stage_e stage,
    input logic [15:0]        time_spent
);

    // entries only while a game runs
    ready_only_in_play: assert property (
        @(posedge clk) disable iff (rst)
        entry_ready |-> (stage == sudoku_pkg::st_play)
    ) else $error("entry_ready high outside st_play");

    won_has_finish: assert property (
        @(posedge clk) disable iff (rst)
        won |-> send_finish
    ) else $error("won high without send_finish");

    // clock frozen once the game is over
    time_frozen_in_done: assert property (
        @(posedge clk) disable iff (rst)
        (stage == sudoku_pkg::st_done) && ($past(stage) == sudoku_pkg::st_done)
            |-> $stable(time_spent)
    ) else $error("time_spent changed in st_done");

endmodule

bind sudoku_top tb_sudoku_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .entry_ready (entry_ready),
    .won         (won),
    .send_finish (send_finish),
    .stage       (stage),
    .time_spent  (time_spent)
);

/* tb_sudoku_top.sv */
`timescale 1ns/10ps

module tb_sudoku_top;

    // about 90 writes at 83 cycles each, two generations, plus margin
    localparam int CYCLE_LIMIT = 20000;

    logic               clk;
    logic               rst;
    logic               connect_req;
    logic               start_req;
    logic               return_req;
    logic               peer_connect;
    logic               peer_start;
    logic               peer_finish;
    logic               entry_valid;
    sudoku_pkg::idx_t   entry_row;
    sudoku_pkg::idx_t   entry_col;
    sudoku_pkg::digit_t entry_digit;
    sudoku_pkg::idx_t   rd_row;
    sudoku_pkg::idx_t   rd_col;
    logic               entry_ready;
    sudoku_pkg::digit_t rd_digit;
    logic               rd_given;
    logic               send_connect;
    logic               send_start;
    logic               send_finish;
    logic               is_slave;
    logic               won;
    sudoku_pkg::stage_e stage;
    logic [15:0]        time_spent;

    sudoku_pkg::digit_t board_digit [81];
    logic               board_given [81];
    int                 offset;
    logic [15:0]        lfsr_state;
    int                 cycle_count = 0;
    int                 error_count;
    int                 test_count;
    int                 failed_tests;

    sudoku_top #(
        .TICK_CYCLES (4),
        .LFSR_SEED   (16'hace1)
    ) u_sudoku_top (
        .clk          (clk),
        .rst          (rst),
        .connect_req  (connect_req),
        .start_req    (start_req),
        .return_req   (return_req),
        .peer_connect (peer_connect),
        .peer_start   (peer_start),
        .peer_finish  (peer_finish),
        .entry_valid  (entry_valid),
        .entry_row    (entry_row),
        .entry_col    (entry_col),
        .entry_digit  (entry_digit),
        .rd_row       (rd_row),
        .rd_col       (rd_col),
        .entry_ready  (entry_ready),
        .rd_digit     (rd_digit),
        .rd_given     (rd_given),
        .send_connect (send_connect),
        .send_start   (send_start),
        .send_finish  (send_finish),
        .is_slave     (is_slave),
        .won          (won),
        .stage        (stage),
        .time_spent   (time_spent)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // taps 16, 15, 13, 4
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[14] ^ s[12] ^ s[3];
        lfsr_step = {s[14:0], fb};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // shifted pattern: 1 + (row*3 + row/3 + col + offset) mod 9
    function automatic sudoku_pkg::digit_t pattern_digit(input int row, input int col,
                                                         input int ofs);
        pattern_digit = 4'((row * 3 + row / 3 + col + ofs) % 9 + 1);
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed", name);
            failed_tests++;
        end
    endtask

    task automatic wait_stage(input sudoku_pkg::stage_e target, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (stage != target && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (stage != target) begin
            $display("stage %s not reached within %0d cycles", target.name(), limit);
            error_count++;
        end
    endtask

    task automatic read_cell(input int row, input int col, output sudoku_pkg::digit_t d,
                             output logic g);
        @(posedge clk);
        rd_row <= 4'(row);
        rd_col <= 4'(col);
        @(negedge clk);
        d = rd_digit;
        g = rd_given;
    endtask

    task automatic read_board();
        for (int i = 0; i < 81; i++) begin
            read_cell(i / 9, i % 9, board_digit[i], board_given[i]);
        end
    endtask

    task automatic write_cell(input int row, input int col, input sudoku_pkg::digit_t digit);
        @(posedge clk);
        entry_valid <= 1'b1;
        entry_row   <= 4'(row);
        entry_col   <= 4'(col);
        entry_digit <= digit;
        // held until the keeper is ready
        @(negedge clk);
        while (!entry_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        entry_valid <= 1'b0;
        // scan running
        @(negedge clk);
        while (!entry_ready && stage == sudoku_pkg::st_play) begin
            @(negedge clk);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_reset();
        int errs;
        errs = error_count;
        @(negedge clk);
        if (stage !== sudoku_pkg::st_idle) begin
            $display("error stage: got 0x%0h, expected 0x%0h", stage, sudoku_pkg::st_idle);
            error_count++;
        end
        if ({send_connect, send_start, send_finish, won} !== 4'h0) begin
            $display("error send_connect/send_start/send_finish/won: got 0x%0h, expected 0x0",
                     {send_connect, send_start, send_finish, won});
            error_count++;
        end
        if (entry_ready !== 1'b0) begin
            $display("error entry_ready: got 0x%0h, expected 0x0", entry_ready);
            error_count++;
        end
        if (time_spent !== 16'h0) begin
            $display("error time_spent: got 0x%0h, expected 0x0", time_spent);
            error_count++;
        end
        finish_test("reset_values", errs);
    endtask

    task automatic start_as_master();
        int errs;
        errs = error_count;
        @(posedge clk);
        connect_req  <= 1'b1;
        peer_connect <= 1'b1;
        @(posedge clk);
        connect_req <= 1'b0;
        wait_stage(sudoku_pkg::st_wait_peer, 4);
        if (send_connect !== 1'b1) begin
            $display("error send_connect: got 0x%0h, expected 0x1", send_connect);
            error_count++;
        end
        @(posedge clk);
        start_req <= 1'b1;
        @(posedge clk);
        start_req <= 1'b0;
        @(negedge clk);
        if (send_start !== 1'b1) begin
            $display("error send_start: got 0x%0h, expected 0x1", send_start);
            error_count++;
        end
        if (is_slave !== 1'b0) begin
            $display("error is_slave: got 0x%0h, expected 0x0", is_slave);
            error_count++;
        end
        // 82 generation cycles and the stage step
        wait_stage(sudoku_pkg::st_play, 100);
        finish_test("start_master", errs);
    endtask

    task automatic verify_pattern();
        int errs;
        int first;
        int base;
        sudoku_pkg::digit_t expected;
        errs  = error_count;
        first = -1;
        read_board();
        for (int i = 0; i < 81; i++) begin
            if (board_given[i] && first < 0) begin
                first = i;
            end
        end
        if (first < 0) begin
            $display("puzzle holds no given cell to derive the offset from");
            error_count++;
        end else begin
            base   = (first / 9) * 3 + (first / 9) / 3 + first % 9;
            offset = ((int'(board_digit[first]) - 1 - base) % 9 + 9) % 9;
            for (int i = 0; i < 81; i++) begin
                expected = board_given[i] ? pattern_digit(i / 9, i % 9, offset) : 4'd0;
                if (board_digit[i] !== expected) begin
                    $display("error rd_digit[%0d]: got 0x%0h, expected 0x%0h",
                             i, board_digit[i], expected);
                    error_count++;
                end
            end
        end
        finish_test("puzzle_pattern", errs);
    endtask

    task automatic protect_given();
        int errs;
        int first;
        int pick;
        int blanks [$];
        sudoku_pkg::digit_t wrong;
        sudoku_pkg::digit_t d;
        logic g;
        errs  = error_count;
        first = -1;
        for (int i = 0; i < 81; i++) begin
            if (board_given[i] && first < 0) begin
                first = i;
            end
            if (!board_given[i]) begin
                blanks.push_back(i);
            end
        end
        if (first >= 0) begin
            wrong = board_digit[first] % 4'd9 + 4'd1;
            write_cell(first / 9, first % 9, wrong);
            read_cell(first / 9, first % 9, d, g);
            if (d !== board_digit[first]) begin
                $display("error rd_digit: got 0x%0h, expected 0x%0h", d, board_digit[first]);
                error_count++;
            end
            if (g !== 1'b1) begin
                $display("error rd_given: got 0x%0h, expected 0x1", g);
                error_count++;
            end
        end
        if (blanks.size() == 0) begin
            $display("puzzle holds no blank cell to write");
            error_count++;
        end else begin
            random_bits(8, pick);
            pick  = blanks[pick % blanks.size()];
            wrong = pattern_digit(pick / 9, pick % 9, offset) % 4'd9 + 4'd1;
            write_cell(pick / 9, pick % 9, wrong);
            read_cell(pick / 9, pick % 9, d, g);
            if (d !== wrong) begin
                $display("error rd_digit: got 0x%0h, expected 0x%0h", d, wrong);
                error_count++;
            end
            if (g !== 1'b0) begin
                $display("error rd_given: got 0x%0h, expected 0x0", g);
                error_count++;
            end
            // a solved board would leave st_play here
            @(negedge clk);
            if (stage !== sudoku_pkg::st_play) begin
                $display("error stage: got 0x%0h, expected 0x%0h", stage, sudoku_pkg::st_play);
                error_count++;
            end
        end
        finish_test("given_protect", errs);
    endtask

    task automatic play_to_win();
        int errs;
        logic [15:0] frozen;
        errs = error_count;
        for (int i = 0; i < 81; i++) begin
            if (!board_given[i]) begin
                write_cell(i / 9, i % 9, pattern_digit(i / 9, i % 9, offset));
            end
        end
        wait_stage(sudoku_pkg::st_done, 10);
        if (won !== 1'b1 || send_finish !== 1'b1) begin
            $display("error won/send_finish: got 0x%0h, expected 0x3", {won, send_finish});
            error_count++;
        end
        if (time_spent == 16'h0) begin
            $display("play time stayed at zero through the game");
            error_count++;
        end
        frozen = time_spent;
        repeat (20) begin
            @(negedge clk);
            if (time_spent !== frozen) begin
                $display("error time_spent: got 0x%0h, expected 0x%0h", time_spent, frozen);
                error_count++;
            end
        end
        finish_test("winning_game", errs);
    endtask

    task automatic lose_as_slave();
        int errs;
        errs = error_count;
        @(posedge clk);
        return_req <= 1'b1;
        @(posedge clk);
        return_req <= 1'b0;
        wait_stage(sudoku_pkg::st_idle, 4);
        if ({send_connect, send_start, send_finish} !== 3'h0) begin
            $display("error send_connect/send_start/send_finish: got 0x%0h, expected 0x0",
                     {send_connect, send_start, send_finish});
            error_count++;
        end
        @(posedge clk);
        connect_req <= 1'b1;
        @(posedge clk);
        connect_req <= 1'b0;
        wait_stage(sudoku_pkg::st_wait_peer, 4);
        @(posedge clk);
        peer_start <= 1'b1;
        wait_stage(sudoku_pkg::st_generate, 4);
        if (is_slave !== 1'b1) begin
            $display("error is_slave: got 0x%0h, expected 0x1", is_slave);
            error_count++;
        end
        @(posedge clk);
        peer_start <= 1'b0;
        wait_stage(sudoku_pkg::st_play, 100);
        @(posedge clk);
        peer_finish <= 1'b1;
        wait_stage(sudoku_pkg::st_done, 4);
        if (won !== 1'b0) begin
            $display("error won: got 0x%0h, expected 0x0", won);
            error_count++;
        end
        @(posedge clk);
        peer_finish <= 1'b0;
        finish_test("slave_loses", errs);
    endtask

    initial begin
        rst          = 1'b1;
        connect_req  = 1'b0;
        start_req    = 1'b0;
        return_req   = 1'b0;
        peer_connect = 1'b0;
        peer_start   = 1'b0;
        peer_finish  = 1'b0;
        entry_valid  = 1'b0;
        entry_row    = '0;
        entry_col    = '0;
        entry_digit  = '0;
        rd_row       = '0;
        rd_col       = '0;
        lfsr_state   = 16'd14042;
        offset       = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        check_reset();
        start_as_master();
        verify_pattern();
        protect_given();
        play_to_win();
        lose_as_slave();

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (failed_tests == 0 && error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sudoku_top.f */
sudoku_pkg.sv
cell_write_if.sv
lfsr.sv
puzzle_generator.sv
board_keeper.sv
game_stage.sv
play_timer.sv
sudoku_top.sv
tb_sudoku_checker.sv
tb_sudoku_top.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert --top-module tb_sudoku_top -Mdir obj_dir -f sudoku_top.f

./obj_dir/Vtb_sudoku_top > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
